// File: rtl/arena_pkg.sv
package arena_pkg;

  // basic words
  typedef logic [9:0] coord_t;  // screen coordinate, wraps at 1024
  typedef logic [2:0] dir_t;
  typedef logic [1:0] hit_t;
  typedef logic [2:0] dmg_t;

  // direction codes, anything else is idle
  localparam dir_t DIR_UP    = 3'd1;
  localparam dir_t DIR_RIGHT = 3'd2;
  localparam dir_t DIR_LEFT  = 3'd3;
  localparam dir_t DIR_DOWN  = 3'd4;

  localparam hit_t HIT  = 2'b00;
  localparam hit_t MISS = 2'b01;

  // wall damage levels
  localparam dmg_t DMG_DEAD         = 3'd4;  // saturated, wall gone
  localparam dmg_t DMG_SOLID_MAX    = 3'd2;  // still blocks tanks
  localparam dmg_t DMG_HITTABLE_MAX = 3'd3;  // still stops bullets

  localparam int NUM_WALLS = 4;

  // motion per frame
  localparam coord_t TANK_STEP   = 10'd1;
  localparam coord_t BULLET_STEP = 10'd5;

  // sprite sizes
  localparam coord_t TANK_SIZE   = 10'd32;
  localparam coord_t BULLET_SIZE = 10'd8;

  // walls at even index lie flat, odd index stand upright
  localparam coord_t H_WALL_W = 10'd64;
  localparam coord_t H_WALL_H = 10'd32;
  localparam coord_t V_WALL_W = 10'd32;
  localparam coord_t V_WALL_H = 10'd64;

endpackage

// File: rtl/tank_move_check.sv
`timescale 1ns/1ns

module tank_move_check (
  input  arena_pkg::coord_t                  tank_x,
  input  arena_pkg::coord_t                  tank_y,
  input  arena_pkg::dir_t                    tank_dir,
  input  arena_pkg::coord_t                  wall_x [arena_pkg::NUM_WALLS],
  input  arena_pkg::coord_t                  wall_y [arena_pkg::NUM_WALLS],
  input  logic [arena_pkg::NUM_WALLS-1:0]    wall_solid,
  output logic                               can_move
);

  arena_pkg::coord_t tank_right;
  arena_pkg::coord_t tank_bottom;
  arena_pkg::coord_t up_edge;
  arena_pkg::coord_t down_edge;
  arena_pkg::coord_t left_edge;
  arena_pkg::coord_t right_edge;

  logic [arena_pkg::NUM_WALLS-1:0] blocked;

  assign tank_right  = tank_x + arena_pkg::TANK_SIZE;
  assign tank_bottom = tank_y + arena_pkg::TANK_SIZE;

  // edge the tank would occupy after one step
  assign up_edge    = tank_y - arena_pkg::TANK_STEP;
  assign down_edge  = tank_bottom + arena_pkg::TANK_STEP;
  assign left_edge  = tank_x - arena_pkg::TANK_STEP;
  assign right_edge = tank_right + arena_pkg::TANK_STEP;

  for (genvar i = 0; i < arena_pkg::NUM_WALLS; i++) begin : g_wall
    arena_pkg::coord_t wall_w;
    arena_pkg::coord_t wall_h;
    arena_pkg::coord_t wall_right;
    arena_pkg::coord_t wall_bottom;
    logic              x_overlap;
    logic              y_overlap;
    logic              meet;

    assign wall_w = (i % 2 == 0) ? arena_pkg::H_WALL_W : arena_pkg::V_WALL_W;
    assign wall_h = (i % 2 == 0) ? arena_pkg::H_WALL_H : arena_pkg::V_WALL_H;

    assign wall_right  = wall_x[i] + wall_w;
    assign wall_bottom = wall_y[i] + wall_h;

    // strict overlap on the cross axis
    assign x_overlap = (tank_right > wall_x[i]) && (tank_x < wall_right);
    assign y_overlap = (tank_bottom > wall_y[i]) && (tank_y < wall_bottom);

    always_comb begin
      unique case (tank_dir)
        arena_pkg::DIR_UP:    meet = (up_edge == wall_bottom) && x_overlap;
        arena_pkg::DIR_RIGHT: meet = (right_edge == wall_x[i]) && y_overlap;
        arena_pkg::DIR_LEFT:  meet = (left_edge == wall_right) && y_overlap;
        arena_pkg::DIR_DOWN:  meet = (down_edge == wall_y[i]) && x_overlap;
        default:              meet = 1'b0;  // idle tank never blocked
      endcase
    end

    assign blocked[i] = meet && wall_solid[i];
  end

  assign can_move = ~|blocked;

endmodule

// File: rtl/bullet_hit_check.sv
`timescale 1ns/1ns

module bullet_hit_check (
  input  arena_pkg::coord_t                  bullet_x,
  input  arena_pkg::coord_t                  bullet_y,
  input  arena_pkg::dir_t                    bullet_dir,
  input  arena_pkg::coord_t                  save_x,
  input  arena_pkg::coord_t                  save_y,
  input  arena_pkg::coord_t                  wall_x [arena_pkg::NUM_WALLS],
  input  arena_pkg::coord_t                  wall_y [arena_pkg::NUM_WALLS],
  input  logic [arena_pkg::NUM_WALLS-1:0]    wall_hittable,
  input  arena_pkg::coord_t                  enemy_x,
  input  arena_pkg::coord_t                  enemy_y,
  output arena_pkg::hit_t                    hit,
  output logic [arena_pkg::NUM_WALLS-1:0]    wall_hit,
  output logic                               tank_hit
);

  logic [arena_pkg::NUM_WALLS-1:0] wall_reach;

  // true when the next bullet step reaches the box at tx, ty of size tw x th
  // and the shooter stood fully on the near side of it
  function automatic logic reaches(
    input arena_pkg::dir_t   dir,
    input arena_pkg::coord_t bx,
    input arena_pkg::coord_t by,
    input arena_pkg::coord_t sx,
    input arena_pkg::coord_t sy,
    input arena_pkg::coord_t tx,
    input arena_pkg::coord_t ty,
    input arena_pkg::coord_t tw,
    input arena_pkg::coord_t th
  );
    arena_pkg::coord_t b_right;
    arena_pkg::coord_t b_bottom;
    arena_pkg::coord_t t_right;
    arena_pkg::coord_t t_bottom;
    arena_pkg::coord_t s_right;
    arena_pkg::coord_t s_bottom;
    arena_pkg::coord_t lead;
    logic              x_overlap;
    logic              y_overlap;
    logic              result;

    b_right  = bx + arena_pkg::BULLET_SIZE;
    b_bottom = by + arena_pkg::BULLET_SIZE;
    t_right  = tx + tw;
    t_bottom = ty + th;
    s_right  = sx + arena_pkg::TANK_SIZE;  // shooter footprint
    s_bottom = sy + arena_pkg::TANK_SIZE;

    x_overlap = (b_right > tx) && (bx < t_right);
    y_overlap = (b_bottom > ty) && (by < t_bottom);

    unique case (dir)
      arena_pkg::DIR_UP: begin
        lead   = by - arena_pkg::BULLET_STEP;
        result = (lead <= t_bottom) && x_overlap && (sy > t_bottom);
      end
      arena_pkg::DIR_RIGHT: begin
        lead   = b_right + arena_pkg::BULLET_STEP;
        result = (lead >= tx) && y_overlap && (s_right < tx);
      end
      arena_pkg::DIR_LEFT: begin
        lead   = bx - arena_pkg::BULLET_STEP;
        result = (lead <= t_right) && y_overlap && (sx > t_right);
      end
      arena_pkg::DIR_DOWN: begin
        lead   = b_bottom + arena_pkg::BULLET_STEP;
        result = (lead >= ty) && x_overlap && (s_bottom < ty);
      end
      default: begin
        lead   = bx;
        result = 1'b0;  // no bullet in flight
      end
    endcase
    return result;
  endfunction

  for (genvar i = 0; i < arena_pkg::NUM_WALLS; i++) begin : g_wall
    arena_pkg::coord_t wall_w;
    arena_pkg::coord_t wall_h;

    assign wall_w = (i % 2 == 0) ? arena_pkg::H_WALL_W : arena_pkg::V_WALL_W;
    assign wall_h = (i % 2 == 0) ? arena_pkg::H_WALL_H : arena_pkg::V_WALL_H;

    assign wall_reach[i] = wall_hittable[i] &&
                           reaches(bullet_dir, bullet_x, bullet_y, save_x, save_y,
                                   wall_x[i], wall_y[i], wall_w, wall_h);
  end

  // lowest index wins, so wall 1 has priority
  assign wall_hit = wall_reach & (~wall_reach + 1'b1);

  // enemy check runs alongside the walls
  assign tank_hit = reaches(bullet_dir, bullet_x, bullet_y, save_x, save_y,
                            enemy_x, enemy_y,
                            arena_pkg::TANK_SIZE, arena_pkg::TANK_SIZE);

  assign hit = (|wall_hit || tank_hit) ? arena_pkg::HIT : arena_pkg::MISS;

endmodule

// File: rtl/wall_damage_bank.sv
`timescale 1ns/1ns

module wall_damage_bank (
  input  logic                               Clk,
  input  logic                               Reset,
  input  logic [arena_pkg::NUM_WALLS-1:0]    wall_hit1,
  input  logic [arena_pkg::NUM_WALLS-1:0]    wall_hit2,
  output arena_pkg::dmg_t                    count1,
  output arena_pkg::dmg_t                    count2,
  output arena_pkg::dmg_t                    count3,
  output arena_pkg::dmg_t                    count4,
  output logic [arena_pkg::NUM_WALLS-1:0]    wall_solid,
  output logic [arena_pkg::NUM_WALLS-1:0]    wall_hittable
);

  logic [arena_pkg::NUM_WALLS-1:0] hit_any;
  arena_pkg::dmg_t                 count [arena_pkg::NUM_WALLS];

  // two bullets on one wall in one cycle count once
  assign hit_any = wall_hit1 | wall_hit2;

  for (genvar i = 0; i < arena_pkg::NUM_WALLS; i++) begin : g_cnt
    always_ff @(posedge Clk or posedge Reset) begin
      if (Reset) begin
        count[i] <= '0;
      end else if (hit_any[i] && (count[i] != arena_pkg::DMG_DEAD)) begin
        count[i] <= count[i] + 1'b1;
      end
    end

    assign wall_solid[i]    = (count[i] <= arena_pkg::DMG_SOLID_MAX);
    assign wall_hittable[i] = (count[i] <= arena_pkg::DMG_HITTABLE_MAX);
  end

  assign count1 = count[0];
  assign count2 = count[1];
  assign count3 = count[2];
  assign count4 = count[3];

endmodule

// File: rtl/arena_collision.sv
`timescale 1ns/1ns

module arena_collision (
  input  logic              Clk,
  input  logic              Reset,
  // wall corners
  input  arena_pkg::coord_t wall1_x,
  input  arena_pkg::coord_t wall1_y,
  input  arena_pkg::coord_t wall2_x,
  input  arena_pkg::coord_t wall2_y,
  input  arena_pkg::coord_t wall3_x,
  input  arena_pkg::coord_t wall3_y,
  input  arena_pkg::coord_t wall4_x,
  input  arena_pkg::coord_t wall4_y,
  input  arena_pkg::coord_t tank1_x,
  input  arena_pkg::coord_t tank1_y,
  input  arena_pkg::coord_t tank2_x,
  input  arena_pkg::coord_t tank2_y,
  // where each tank stood when it fired
  input  arena_pkg::coord_t save1_x,
  input  arena_pkg::coord_t save1_y,
  input  arena_pkg::coord_t save2_x,
  input  arena_pkg::coord_t save2_y,
  input  arena_pkg::coord_t bullet1_x,
  input  arena_pkg::coord_t bullet1_y,
  input  arena_pkg::coord_t bullet2_x,
  input  arena_pkg::coord_t bullet2_y,
  input  arena_pkg::dir_t   tank1_dir,
  input  arena_pkg::dir_t   tank2_dir,
  input  arena_pkg::dir_t   bullet1_dir,
  input  arena_pkg::dir_t   bullet2_dir,
  output logic              can_move1,
  output logic              can_move2,
  output logic              tank1_alive,
  output logic              tank2_alive,
  output arena_pkg::hit_t   hit1,
  output arena_pkg::hit_t   hit2,
  output arena_pkg::dmg_t   count1,
  output arena_pkg::dmg_t   count2,
  output arena_pkg::dmg_t   count3,
  output arena_pkg::dmg_t   count4
);

  arena_pkg::coord_t               wall_x [arena_pkg::NUM_WALLS];
  arena_pkg::coord_t               wall_y [arena_pkg::NUM_WALLS];
  logic [arena_pkg::NUM_WALLS-1:0] wall_solid;
  logic [arena_pkg::NUM_WALLS-1:0] wall_hittable;
  logic [arena_pkg::NUM_WALLS-1:0] wall_hit1;
  logic [arena_pkg::NUM_WALLS-1:0] wall_hit2;
  logic                            tank_hit1;  // bullet 1 on tank 2
  logic                            tank_hit2;  // bullet 2 on tank 1

  assign wall_x = '{wall1_x, wall2_x, wall3_x, wall4_x};
  assign wall_y = '{wall1_y, wall2_y, wall3_y, wall4_y};

  tank_move_check u_move1 (
    .tank_x     (tank1_x),
    .tank_y     (tank1_y),
    .tank_dir   (tank1_dir),
    .wall_x     (wall_x),
    .wall_y     (wall_y),
    .wall_solid (wall_solid),
    .can_move   (can_move1)
  );

  tank_move_check u_move2 (
    .tank_x     (tank2_x),
    .tank_y     (tank2_y),
    .tank_dir   (tank2_dir),
    .wall_x     (wall_x),
    .wall_y     (wall_y),
    .wall_solid (wall_solid),
    .can_move   (can_move2)
  );

  bullet_hit_check u_bullet1 (
    .bullet_x      (bullet1_x),
    .bullet_y      (bullet1_y),
    .bullet_dir    (bullet1_dir),
    .save_x        (save1_x),
    .save_y        (save1_y),
    .wall_x        (wall_x),
    .wall_y        (wall_y),
    .wall_hittable (wall_hittable),
    .enemy_x       (tank2_x),
    .enemy_y       (tank2_y),
    .hit           (hit1),
    .wall_hit      (wall_hit1),
    .tank_hit      (tank_hit1)
  );

  bullet_hit_check u_bullet2 (
    .bullet_x      (bullet2_x),
    .bullet_y      (bullet2_y),
    .bullet_dir    (bullet2_dir),
    .save_x        (save2_x),
    .save_y        (save2_y),
    .wall_x        (wall_x),
    .wall_y        (wall_y),
    .wall_hittable (wall_hittable),
    .enemy_x       (tank1_x),
    .enemy_y       (tank1_y),
    .hit           (hit2),
    .wall_hit      (wall_hit2),
    .tank_hit      (tank_hit2)
  );

  wall_damage_bank u_damage (
    .Clk           (Clk),
    .Reset         (Reset),
    .wall_hit1     (wall_hit1),
    .wall_hit2     (wall_hit2),
    .count1        (count1),
    .count2        (count2),
    .count3        (count3),
    .count4        (count4),
    .wall_solid    (wall_solid),
    .wall_hittable (wall_hittable)
  );

  assign tank1_alive = ~tank_hit2;
  assign tank2_alive = ~tank_hit1;

endmodule

// File: sim/arena_collision_chk.sv
`timescale 1ns/1ns

module arena_collision_chk (
  input logic                            Clk,
  input logic                            Reset,
  input arena_pkg::dmg_t                 count1,
  input arena_pkg::dmg_t                 count2,
  input arena_pkg::dmg_t                 count3,
  input arena_pkg::dmg_t                 count4,
  input logic [arena_pkg::NUM_WALLS-1:0] wall_hit1,
  input logic [arena_pkg::NUM_WALLS-1:0] wall_hit2,
  input arena_pkg::dir_t                 bullet1_dir,
  input arena_pkg::dir_t                 bullet2_dir,
  input arena_pkg::hit_t                 hit1,
  input arena_pkg::hit_t                 hit2,
  input logic                            tank1_alive,
  input logic                            tank2_alive
);

  int fail_count = 0;  // failures seen so far

  arena_pkg::dmg_t                 count [arena_pkg::NUM_WALLS];
  logic [arena_pkg::NUM_WALLS-1:0] any_hit;
  logic                            idle1;
  logic                            idle2;

  assign count   = '{count1, count2, count3, count4};
  assign any_hit = wall_hit1 | wall_hit2;
  assign idle1   = (bullet1_dir < arena_pkg::DIR_UP) || (bullet1_dir > arena_pkg::DIR_DOWN);
  assign idle2   = (bullet2_dir < arena_pkg::DIR_UP) || (bullet2_dir > arena_pkg::DIR_DOWN);

  for (genvar i = 0; i < arena_pkg::NUM_WALLS; i++) begin : g_wall
    // one step per cycle no matter how many bullets land
    a_step: assert property (@(posedge Clk) disable iff (Reset)
        any_hit[i] && (count[i] != arena_pkg::DMG_DEAD) |=> count[i] == $past(count[i]) + 3'd1)
      else begin
        fail_count++;
        $error("wall %0d count did not rise by one after a hit", i + 1);
      end

    a_hold: assert property (@(posedge Clk) disable iff (Reset)
        !any_hit[i] |=> $stable(count[i]))
      else begin
        fail_count++;
        $error("wall %0d count changed without a hit", i + 1);
      end

    // a destroyed wall is out of play
    a_dead: assert property (@(posedge Clk) disable iff (Reset)
        (count[i] <= arena_pkg::DMG_DEAD) && !((count[i] == arena_pkg::DMG_DEAD) && any_hit[i]))
      else begin
        fail_count++;
        $error("wall %0d went past destroyed or was hit while destroyed", i + 1);
      end
  end

  a_onehot: assert property (@(posedge Clk) disable iff (Reset)
      $onehot0(wall_hit1) && $onehot0(wall_hit2))
    else begin
      fail_count++;
      $error("a bullet hit more than one wall in one cycle");
    end

  a_idle: assert property (@(posedge Clk) disable iff (Reset)
      (!idle1 || ((hit1 == arena_pkg::MISS) && tank2_alive && (wall_hit1 == '0))) &&
      (!idle2 || ((hit2 == arena_pkg::MISS) && tank1_alive && (wall_hit2 == '0))))
    else begin
      fail_count++;
      $error("an idle bullet produced a hit");
    end

endmodule

// File: sim/arena_collision_tb.sv
`timescale 1ns/1ns

module arena_collision_tb;

  localparam int RESET_CYCLES = 16;
  localparam int SWEEP_N      = 20;
  localparam int TEST_CYCLES  = RESET_CYCLES + SWEEP_N + 60;  // every test rounded up
  localparam int LIMIT_NS     = 2 * TEST_CYCLES * 20;

  logic              Clk;
  logic              Reset;
  arena_pkg::coord_t wall1_x, wall1_y, wall2_x, wall2_y;
  arena_pkg::coord_t wall3_x, wall3_y, wall4_x, wall4_y;
  arena_pkg::coord_t tank1_x, tank1_y, tank2_x, tank2_y;
  arena_pkg::coord_t save1_x, save1_y, save2_x, save2_y;
  arena_pkg::coord_t bullet1_x, bullet1_y, bullet2_x, bullet2_y;
  arena_pkg::dir_t   tank1_dir, tank2_dir, bullet1_dir, bullet2_dir;
  logic              can_move1, can_move2, tank1_alive, tank2_alive;
  arena_pkg::hit_t   hit1, hit2;
  arena_pkg::dmg_t   count1, count2, count3, count4;

  int errors       = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int fails_before = 0;
  int seed         = 10727;

  arena_collision u_dut (.*);

  bind arena_collision arena_collision_chk u_chk (.*);

  initial begin
    Clk = 1'b0;
    forever #10 Clk = ~Clk;
  end

  initial begin
    #(LIMIT_NS);
    $display("watchdog: run did not finish within %0d ns", LIMIT_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

  function automatic int fail_total();
    return errors + u_dut.u_chk.fail_count;
  endfunction

  task automatic expect_val(input string what, input int got, input int want);
    assert (got == want) else begin
      errors++;
      $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic expect_counts(input int c1, input int c2, input int c3, input int c4);
    expect_val("count1", int'(count1), c1);
    expect_val("count2", int'(count2), c2);
    expect_val("count3", int'(count3), c3);
    expect_val("count4", int'(count4), c4);
  endtask

  task automatic end_test(input string name);
    int fails;
    fails = fail_total() - fails_before;
    tests_run++;
    if (fails == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d check(s) failed", tests_run, name, fails);
    end
    fails_before = fail_total();
  endtask

  // both tanks on one spot so both checkers see the same case
  task automatic try_move(input arena_pkg::dir_t dir, input arena_pkg::coord_t x,
                          input arena_pkg::coord_t y, input logic want);
    @(posedge Clk);
    {tank1_x, tank1_y, tank1_dir} <= {x, y, dir};
    {tank2_x, tank2_y, tank2_dir} <= {x, y, dir};
    @(negedge Clk);
    expect_val("can_move1", int'(can_move1), int'(want));
    expect_val("can_move2", int'(can_move2), int'(want));
  endtask

  task automatic aim1(input arena_pkg::dir_t dir, input arena_pkg::coord_t bx,
                      input arena_pkg::coord_t by, input arena_pkg::coord_t sx,
                      input arena_pkg::coord_t sy);
    {bullet1_dir, bullet1_x, bullet1_y} <= {dir, bx, by};
    {save1_x, save1_y} <= {sx, sy};
  endtask

  task automatic aim2(input arena_pkg::dir_t dir, input arena_pkg::coord_t bx,
                      input arena_pkg::coord_t by, input arena_pkg::coord_t sx,
                      input arena_pkg::coord_t sy);
    {bullet2_dir, bullet2_x, bullet2_y} <= {dir, bx, by};
    {save2_x, save2_y} <= {sx, sy};
  endtask

  // bullets go idle and the count step shows by the following negedge
  task automatic land();
    @(posedge Clk);
    bullet1_dir <= 3'd0;
    bullet2_dir <= 3'd0;
    @(negedge Clk);
  endtask

  task automatic shot1(input arena_pkg::dir_t dir, input arena_pkg::coord_t bx,
                       input arena_pkg::coord_t by, input arena_pkg::coord_t sx,
                       input arena_pkg::coord_t sy, input arena_pkg::hit_t want);
    @(posedge Clk);
    aim1(dir, bx, by, sx, sy);
    @(negedge Clk);
    expect_val("hit1", int'(hit1), int'(want));
    land();
  endtask

  initial begin : stimulus
    logic [31:0]       r;
    arena_pkg::coord_t jit;

    Reset = 1'b1;
    {wall1_x, wall1_y} = {10'd100, 10'd100};  // flat
    {wall2_x, wall2_y} = {10'd400, 10'd100};  // upright
    {wall3_x, wall3_y} = {10'd100, 10'd400};
    {wall4_x, wall4_y} = {10'd400, 10'd400};
    {tank1_x, tank1_y, tank2_x, tank2_y} = {10'd700, 10'd700, 10'd800, 10'd600};
    {save1_x, save1_y, save2_x, save2_y} = '0;
    {bullet1_x, bullet1_y, bullet2_x, bullet2_y} = '0;
    {tank1_dir, tank2_dir, bullet1_dir, bullet2_dir} = '0;

    repeat (RESET_CYCLES) @(posedge Clk);
    Reset <= 1'b0;
    @(negedge Clk);
    expect_counts(0, 0, 0, 0);
    expect_val("can_move1", int'(can_move1), 1);
    expect_val("can_move2", int'(can_move2), 1);
    expect_val("tank1_alive", int'(tank1_alive), 1);
    expect_val("tank2_alive", int'(tank2_alive), 1);
    expect_val("hit1", int'(hit1), int'(arena_pkg::MISS));
    expect_val("hit2", int'(hit2), int'(arena_pkg::MISS));
    end_test("reset state");

    // wall 1 spans x 100..164, y 100..132
    try_move(arena_pkg::DIR_RIGHT, 10'd67, 10'd100, 1'b0);
    try_move(arena_pkg::DIR_RIGHT, 10'd66, 10'd100, 1'b1);
    try_move(arena_pkg::DIR_RIGHT, 10'd67, 10'd132, 1'b1);
    try_move(arena_pkg::DIR_LEFT, 10'd165, 10'd100, 1'b0);
    try_move(arena_pkg::DIR_LEFT, 10'd166, 10'd100, 1'b1);
    try_move(arena_pkg::DIR_LEFT, 10'd165, 10'd68, 1'b1);
    try_move(arena_pkg::DIR_UP, 10'd100, 10'd133, 1'b0);
    try_move(arena_pkg::DIR_UP, 10'd100, 10'd134, 1'b1);
    try_move(arena_pkg::DIR_UP, 10'd164, 10'd133, 1'b1);
    try_move(arena_pkg::DIR_DOWN, 10'd100, 10'd67, 1'b0);
    try_move(arena_pkg::DIR_DOWN, 10'd100, 10'd66, 1'b1);
    try_move(arena_pkg::DIR_DOWN, 10'd68, 10'd67, 1'b1);
    for (int n = 0; n < SWEEP_N; n++) begin
      r   = $random(seed);
      jit = {6'd0, r[3:0]};
      if (n % 2 == 0) begin
        try_move(arena_pkg::DIR_RIGHT, 10'd66 - jit, 10'd100 - {6'd0, r[7:4]}, 1'b1);
      end else begin
        try_move(arena_pkg::DIR_UP, 10'd100, 10'd134 + jit, 1'b1);  // never on the edge
      end
    end
    end_test("tank blocking");

    @(posedge Clk);
    {tank1_x, tank1_y, tank1_dir} <= {10'd700, 10'd700, 3'd0};
    {tank2_x, tank2_y, tank2_dir} <= {10'd800, 10'd600, 3'd0};
    shot1(arena_pkg::DIR_RIGHT, 10'd390, 10'd120, 10'd300, 10'd120, arena_pkg::HIT);
    expect_counts(0, 1, 0, 0);
    shot1(arena_pkg::DIR_RIGHT, 10'd390, 10'd120, 10'd380, 10'd120, arena_pkg::MISS);
    expect_counts(0, 1, 0, 0);
    // shooter left of walls 1 and 2 so only wall 1 counts
    shot1(arena_pkg::DIR_RIGHT, 10'd390, 10'd120, 10'd0, 10'd120, arena_pkg::HIT);
    expect_counts(1, 1, 0, 0);
    end_test("wall hit");

    // tank parked on the far side of wall 2 and out of the bullet path
    shot1(arena_pkg::DIR_RIGHT, 10'd390, 10'd120, 10'd300, 10'd120, arena_pkg::HIT);
    try_move(arena_pkg::DIR_LEFT, 10'd433, 10'd100, 1'b0);
    shot1(arena_pkg::DIR_RIGHT, 10'd390, 10'd120, 10'd300, 10'd120, arena_pkg::HIT);
    try_move(arena_pkg::DIR_LEFT, 10'd433, 10'd100, 1'b1);
    shot1(arena_pkg::DIR_RIGHT, 10'd390, 10'd120, 10'd300, 10'd120, arena_pkg::HIT);
    expect_counts(1, 4, 0, 0);
    shot1(arena_pkg::DIR_RIGHT, 10'd390, 10'd120, 10'd300, 10'd120, arena_pkg::MISS);
    expect_counts(1, 4, 0, 0);
    end_test("wall destruction");

    @(posedge Clk);
    {tank1_x, tank1_y, tank2_x, tank2_y} <= {10'd600, 10'd200, 10'd110, 10'd395};
    aim1(arena_pkg::DIR_DOWN, 10'd120, 10'd390, 10'd100, 10'd300);  // wall 3 and tank 2
    aim2(arena_pkg::DIR_LEFT, 10'd636, 10'd210, 10'd700, 10'd200);
    @(negedge Clk);
    expect_val("hit1", int'(hit1), int'(arena_pkg::HIT));
    expect_val("hit2", int'(hit2), int'(arena_pkg::HIT));
    expect_val("tank1_alive", int'(tank1_alive), 0);
    expect_val("tank2_alive", int'(tank2_alive), 0);
    land();
    expect_counts(1, 4, 1, 0);
    @(posedge Clk);
    aim2(arena_pkg::DIR_LEFT, 10'd636, 10'd210, 10'd620, 10'd200);
    @(negedge Clk);
    expect_val("hit2", int'(hit2), int'(arena_pkg::MISS));
    expect_val("tank1_alive", int'(tank1_alive), 1);
    land();
    end_test("enemy tank hit");

    @(posedge Clk);
    {tank1_x, tank1_y, tank2_x, tank2_y} <= {10'd700, 10'd700, 10'd800, 10'd600};
    aim1(arena_pkg::DIR_RIGHT, 10'd390, 10'd420, 10'd300, 10'd420);
    aim2(arena_pkg::DIR_LEFT, 10'd436, 10'd440, 10'd500, 10'd440);
    @(negedge Clk);
    expect_val("hit1", int'(hit1), int'(arena_pkg::HIT));
    expect_val("hit2", int'(hit2), int'(arena_pkg::HIT));
    land();
    expect_counts(1, 4, 1, 1);
    end_test("shared wall hit");

    $display("%0d tests, %0d failed, %0d failed checks", tests_run, tests_failed, fail_total());
    if (fail_total() == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: arena_collision.f
rtl/arena_pkg.sv
rtl/tank_move_check.sv
rtl/bullet_hit_check.sv
rtl/wall_damage_bank.sv
rtl/arena_collision.sv
sim/arena_collision_chk.sv
sim/arena_collision_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the arena_collision testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module arena_collision_tb \
  -f arena_collision.f

# raise the error limit so assertion errors do not stop the run early
status=0
./obj_dir/Varena_collision_tb +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
